// File: dcache_pkg.sv
package dcache_pkg;

    typedef logic [31:0] word_t;       // one data word
    typedef logic [31:0] addr_t;       // byte address
    typedef logic [1:0]  size_t;       // access size code
    typedef logic [3:0]  byte_mask_t;  // one enable per byte lane

    // size codes, same encoding as the core's data_size
    localparam size_t SIZE_BYTE = 2'd0;
    localparam size_t SIZE_HALF = 2'd1;
    localparam size_t SIZE_WORD = 2'd2;

    // cache controller states
    typedef enum logic [1:0] {
        IDLE      = 2'b00,  // hits served here
        READ_MISS = 2'b01,  // waiting on a line fill
        WRITE_MEM = 2'b11   // write-through in flight
    } cache_state_t;

    // backing memory states
    typedef enum logic {
        MEM_IDLE = 1'b0,
        MEM_BUSY = 1'b1
    } mem_state_t;

endpackage

// File: byte_merge.sv
`timescale 1ns/1ps

module byte_merge import dcache_pkg::*; (
    input  logic [1:0] addr_low,
    input  size_t      size,
    input  word_t      old_word,
    input  word_t      new_word,
    output byte_mask_t mask,
    output word_t      merged
);

    // lane decode from size and the low address bits
    always_comb begin
        case (size)
            SIZE_BYTE: mask = byte_mask_t'(4'b0001 << addr_low);
            SIZE_HALF: mask = addr_low[1] ? 4'b1100 : 4'b0011;  // upper or lower pair
            SIZE_WORD: mask = 4'b1111;
            default:   mask = 4'b1111;                         // treat reserved code as word
        endcase
    end

    // masked lanes from the new word, the rest kept
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            merged[8*i +: 8] = mask[i] ? new_word[8*i +: 8] : old_word[8*i +: 8];
        end
    end

endmodule

// File: dcache_write_through.sv
`timescale 1ns/1ps

module dcache_write_through import dcache_pkg::*; #(
    parameter int INDEX_WIDTH  = 4,
    parameter int OFFSET_WIDTH = 2
) (
    input  logic  clk,
    input  logic  rst,

    // core side
    input  logic  cpu_req,
    input  logic  cpu_wr,
    input  size_t cpu_size,
    input  addr_t cpu_addr,
    input  word_t cpu_wdata,
    output word_t cpu_rdata,
    output logic  cpu_addr_ok,
    output logic  cpu_data_ok,

    // memory side
    output logic  mem_req,
    output logic  mem_wr,
    output size_t mem_size,
    output addr_t mem_addr,
    output word_t mem_wdata,
    input  word_t mem_rdata,
    input  logic  mem_addr_ok,
    input  logic  mem_data_ok
);

    localparam int TAG_WIDTH = 32 - INDEX_WIDTH - OFFSET_WIDTH;
    localparam int DEPTH     = 1 << INDEX_WIDTH;

    // one word per line
    logic                 line_valid [DEPTH];
    logic [TAG_WIDTH-1:0] line_tag   [DEPTH];
    word_t                line_data  [DEPTH];

    logic [OFFSET_WIDTH-1:0] offset;
    logic [INDEX_WIDTH-1:0]  index;
    logic [TAG_WIDTH-1:0]    tag;

    logic [TAG_WIDTH-1:0]    tag_save;
    logic [INDEX_WIDTH-1:0]  index_save;

    cache_state_t state;
    cache_state_t state_next;

    word_t line_word;
    word_t merged_word;
    logic  hit;
    logic  read_hit;
    logic  write_hit;
    logic  addr_rcv;   // memory took the address, waiting for data
    logic  fill;

    assign offset = cpu_addr[OFFSET_WIDTH-1:0];
    assign index  = cpu_addr[INDEX_WIDTH+OFFSET_WIDTH-1:OFFSET_WIDTH];
    assign tag    = cpu_addr[31:INDEX_WIDTH+OFFSET_WIDTH];

    assign line_word = line_data[index];
    assign hit       = line_valid[index] && (line_tag[index] == tag);

    // hits only count while idle
    assign read_hit  = (state == IDLE) && cpu_req && !cpu_wr && hit;
    assign write_hit = (state == IDLE) && cpu_req && cpu_wr && hit;
    assign fill      = (state == READ_MISS) && mem_data_ok;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (cpu_req && cpu_wr) begin
                    state_next = WRITE_MEM;   // every write goes to memory
                end else if (cpu_req && !hit) begin
                    state_next = READ_MISS;
                end
            end
            READ_MISS: if (mem_data_ok) state_next = IDLE;
            WRITE_MEM: if (mem_data_ok) state_next = IDLE;
            default:   state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            addr_rcv <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            addr_rcv <= 1'b1;
        end else if (mem_data_ok) begin
            addr_rcv <= 1'b0;
        end
    end

    // request fields are held by the core, pass them through
    assign mem_req   = (state != IDLE) && !addr_rcv;
    assign mem_wr    = (state == WRITE_MEM);
    assign mem_size  = cpu_size;
    assign mem_addr  = cpu_addr;
    assign mem_wdata = cpu_wdata;

    assign cpu_rdata   = hit ? line_word : mem_rdata;
    assign cpu_addr_ok = read_hit || (mem_req && mem_addr_ok);
    assign cpu_data_ok = read_hit || mem_data_ok;

    // line slot for the fill
    always_ff @(posedge clk) begin
        if ((state == IDLE) && cpu_req) begin
            tag_save   <= tag;
            index_save <= index;
        end
    end

    byte_merge u_merge (
        .addr_low (offset[1:0]),
        .size     (cpu_size),
        .old_word (line_word),
        .new_word (cpu_wdata),
        .mask     (),
        .merged   (merged_word)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                line_valid[i] <= 1'b0;
            end
        end else if (fill) begin
            line_valid[index_save] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            line_tag[index_save]  <= tag_save;
            line_data[index_save] <= mem_rdata;
        end else if (write_hit) begin
            line_data[index] <= merged_word;   // merged once, in the request cycle
        end
    end

endmodule

// File: sram_like_mem.sv
`timescale 1ns/1ps

module sram_like_mem import dcache_pkg::*; #(
    parameter int MEM_LATENCY   = 3,
    parameter int MEM_WORD_BITS = 10
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  req,
    input  logic  wr,
    input  size_t size,
    input  addr_t addr,
    input  word_t wdata,
    output word_t rdata,
    output logic  addr_ok,
    output logic  data_ok
);

    localparam int DEPTH = 1 << MEM_WORD_BITS;
    localparam int CNT_W = (MEM_LATENCY > 1) ? $clog2(MEM_LATENCY) : 1;

    word_t mem_array [DEPTH];

    mem_state_t       state;
    logic [CNT_W-1:0] count;   // cycles left before data_ok

    // request latched at accept
    logic  wr_q;
    size_t size_q;
    addr_t addr_q;
    word_t wdata_q;

    logic [MEM_WORD_BITS-1:0] word_idx;
    word_t merged_word;

    assign addr_ok  = (state == MEM_IDLE) && req;
    assign data_ok  = (state == MEM_BUSY) && (count == '0);
    assign word_idx = addr_q[MEM_WORD_BITS+1:2];  // wraps on memory size
    assign rdata    = mem_array[word_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= MEM_IDLE;
            count <= '0;
        end else if (addr_ok) begin
            state <= MEM_BUSY;
            count <= CNT_W'(MEM_LATENCY - 1);
        end else if (data_ok) begin
            state <= MEM_IDLE;
        end else if (state == MEM_BUSY) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            wr_q    <= wr;
            size_q  <= size;
            addr_q  <= addr;
            wdata_q <= wdata;
        end
    end

    byte_merge u_merge (
        .addr_low (addr_q[1:0]),
        .size     (size_q),
        .old_word (mem_array[word_idx]),
        .new_word (wdata_q),
        .mask     (),
        .merged   (merged_word)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_array[i] <= '0;
            end
        end else if (data_ok && wr_q) begin
            mem_array[word_idx] <= merged_word;  // write lands with data_ok
        end
    end

endmodule

// File: dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int INDEX_WIDTH   = 4,
    parameter int OFFSET_WIDTH  = 2,
    parameter int MEM_LATENCY   = 3,
    parameter int MEM_WORD_BITS = 10
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  data_req,
    input  logic  data_wr,
    input  size_t data_size,
    input  addr_t data_addr,
    input  word_t data_wdata,
    output word_t data_rdata,
    output logic  data_addr_ok,
    output logic  data_data_ok
);

    // cache to memory
    logic  mem_req;
    logic  mem_wr;
    size_t mem_size;
    addr_t mem_addr;
    word_t mem_wdata;
    word_t mem_rdata;
    logic  mem_addr_ok;
    logic  mem_data_ok;

    dcache_write_through #(
        .INDEX_WIDTH  (INDEX_WIDTH),
        .OFFSET_WIDTH (OFFSET_WIDTH)
    ) u_cache (
        .clk         (clk),
        .rst         (rst),
        .cpu_req     (data_req),
        .cpu_wr      (data_wr),
        .cpu_size    (data_size),
        .cpu_addr    (data_addr),
        .cpu_wdata   (data_wdata),
        .cpu_rdata   (data_rdata),
        .cpu_addr_ok (data_addr_ok),
        .cpu_data_ok (data_data_ok),
        .mem_req     (mem_req),
        .mem_wr      (mem_wr),
        .mem_size    (mem_size),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .mem_rdata   (mem_rdata),
        .mem_addr_ok (mem_addr_ok),
        .mem_data_ok (mem_data_ok)
    );

    sram_like_mem #(
        .MEM_LATENCY   (MEM_LATENCY),
        .MEM_WORD_BITS (MEM_WORD_BITS)
    ) u_mem (
        .clk     (clk),
        .rst     (rst),
        .req     (mem_req),
        .wr      (mem_wr),
        .size    (mem_size),
        .addr    (mem_addr),
        .wdata   (mem_wdata),
        .rdata   (mem_rdata),
        .addr_ok (mem_addr_ok),
        .data_ok (mem_data_ok)
    );

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD        = 100,
    parameter int RESET_CYCLES  = 2,
    parameter int RELEASE_DELAY = 10
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #RELEASE_DELAY rst = 1'b0;  // released off the edge, like the other inputs
    end

endmodule

// File: dcache_assertions.sv
`timescale 1ns/1ps

module dcache_assertions import dcache_pkg::*; (
    input logic         clk,
    input logic         rst,
    input cache_state_t state,
    input logic         cpu_wr,
    input logic         cpu_data_ok,
    input logic         mem_req,
    input logic         mem_addr_ok,
    input logic         mem_data_ok
);

    int fail_count = 0;

    // memory answers only a request in flight
    no_resp_in_idle: assert property (@(posedge clk) disable iff (rst)
        (state == IDLE) |-> !mem_data_ok)
        else begin
            $error("memory answered while the cache is idle");
            fail_count++;
        end

    // request held until the memory takes it
    req_held: assert property (@(posedge clk) disable iff (rst)
        (mem_req && !mem_addr_ok) |=> mem_req)
        else begin
            $error("mem_req dropped before mem_addr_ok");
            fail_count++;
        end

    write_done_with_mem: assert property (@(posedge clk) disable iff (rst)
        (cpu_data_ok && cpu_wr) |-> (mem_data_ok && (state == WRITE_MEM)))
        else begin
            $error("write completed to the core outside a write-through response");
            fail_count++;
        end

    legal_state: assert property (@(posedge clk) disable iff (rst)
        state inside {IDLE, READ_MISS, WRITE_MEM})
        else begin
            $error("cache state left the legal encodings");
            fail_count++;
        end

endmodule

bind dcache_write_through dcache_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .cpu_wr      (cpu_wr),
    .cpu_data_ok (cpu_data_ok),
    .mem_req     (mem_req),
    .mem_addr_ok (mem_addr_ok),
    .mem_data_ok (mem_data_ok)
);

// File: tb_checker.sv
`timescale 1ns/1ps

module tb_checker import dcache_pkg::*; #(
    parameter int INDEX_WIDTH   = 4,
    parameter int MEM_LATENCY   = 3,
    parameter int MEM_WORD_BITS = 10
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  data_req,
    input  logic  data_wr,
    input  size_t data_size,
    input  addr_t data_addr,
    input  word_t data_wdata,
    input  word_t data_rdata,
    input  logic  data_addr_ok,
    input  logic  data_data_ok,
    output int    errors,
    output int    read_hits,
    output int    read_misses,
    output int    writes
);

    localparam int TAG_WIDTH = 32 - INDEX_WIDTH - 2;
    localparam int LINES     = 1 << INDEX_WIDTH;
    localparam int WORDS     = 1 << MEM_WORD_BITS;

    word_t                ref_mem   [WORDS];
    logic                 ref_valid [LINES];
    logic [TAG_WIDTH-1:0] ref_tag   [LINES];

    // request being tracked
    logic                     busy;
    logic                     req_wr;
    size_t                    req_size;
    addr_t                    req_addr;
    word_t                    req_wdata;
    logic                     pred_hit;
    logic                     addr_seen;
    logic                     late_told;
    int                       cyc;
    int                       done_cycle;
    int                       addr_cycle;
    logic [MEM_WORD_BITS-1:0] widx;
    logic [INDEX_WIDTH-1:0]   lidx;
    logic [TAG_WIDTH-1:0]     ltag;

    // store rule: only the lanes picked by size and low address bits change
    function automatic word_t apply_store(input word_t old_word, input word_t new_word,
                                          input size_t size, input logic [1:0] low);
        word_t result;
        result = old_word;
        case (size)
            SIZE_BYTE: result[8*low +: 8] = new_word[8*low +: 8];
            SIZE_HALF: result[16*low[1] +: 16] = new_word[16*low[1] +: 16];
            default:   result = new_word;
        endcase
        return result;
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            ref_mem[i] = '0;
        end
        errors      = 0;
        read_hits   = 0;
        read_misses = 0;
        writes      = 0;
        busy        = 1'b0;
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (rst) begin
            busy = 1'b0;
            for (int i = 0; i < LINES; i++) begin
                ref_valid[i] = 1'b0;
            end
        end else begin
            if (!busy && data_req) begin
                busy       = 1'b1;   // cycle 0 of a new request
                cyc        = 0;
                req_wr     = data_wr;
                req_size   = data_size;
                req_addr   = data_addr;
                req_wdata  = data_wdata;
                widx       = data_addr[MEM_WORD_BITS+1:2];
                lidx       = data_addr[INDEX_WIDTH+1:2];
                ltag       = data_addr[31:INDEX_WIDTH+2];
                pred_hit   = ref_valid[lidx] && (ref_tag[lidx] == ltag);
                done_cycle = (!data_wr && pred_hit) ? 0 : 1 + MEM_LATENCY;
                addr_cycle = (!data_wr && pred_hit) ? 0 : 1;
                addr_seen  = 1'b0;
                late_told  = 1'b0;
            end else if (busy) begin
                cyc++;
            end

            if (busy) begin
                if (data_addr_ok) begin
                    addr_seen = 1'b1;
                    if (cyc != addr_cycle) begin
                        $display("%0t: address of request %h accepted in cycle %0d, expected %0d",
                                 $time, req_addr, cyc, addr_cycle);
                        errors++;
                    end
                end
                if (data_data_ok) begin
                    if (cyc != done_cycle) begin
                        $display("%0t: request %h finished in cycle %0d, expected cycle %0d",
                                 $time, req_addr, cyc, done_cycle);
                        errors++;
                    end
                    if (!addr_seen) begin
                        $display("%0t: request %h finished without an address accept",
                                 $time, req_addr);
                        errors++;
                    end
                    if (!req_wr) begin
                        if (data_rdata !== ref_mem[widx]) begin
                            $display("[FAIL] %0t data_rdata expected %h actual %h",
                                     $time, ref_mem[widx], data_rdata);
                            errors++;
                        end
                        if (pred_hit) begin
                            read_hits++;
                        end else begin
                            read_misses++;
                            ref_valid[lidx] = 1'b1;  // fill on read miss
                            ref_tag[lidx]   = ltag;
                        end
                    end else begin
                        writes++;   // no allocate, line tags untouched
                        ref_mem[widx] = apply_store(ref_mem[widx], req_wdata, req_size,
                                                    req_addr[1:0]);
                    end
                    busy = 1'b0;
                end else if (cyc > done_cycle && !late_told) begin
                    $display("%0t: request %h still waiting for data_data_ok in cycle %0d",
                             $time, req_addr, cyc);
                    errors++;
                    late_told = 1'b1;
                end
            end else if (data_addr_ok || data_data_ok) begin
                $display("%0t: handshake output high while no request is presented", $time);
                errors++;
            end
        end
    end

endmodule

// File: tb_dcache_top.sv
`timescale 1ns/1ps

module tb_dcache_top import dcache_pkg::*; ();

    localparam int INDEX_WIDTH    = 4;
    localparam int MEM_LATENCY    = 3;
    localparam int MEM_WORD_BITS  = 10;
    localparam int N_OPS          = 400;
    localparam int TIMEOUT_CYCLES = N_OPS * (MEM_LATENCY + 4) + 20;
    localparam int DRIVE_DELAY    = 10;
    localparam logic [31:0] SEED  = 32'h4c4a;

    logic  clk;
    logic  rst;
    logic  data_req;
    logic  data_wr;
    size_t data_size;
    addr_t data_addr;
    word_t data_wdata;
    word_t data_rdata;
    logic  data_addr_ok;
    logic  data_data_ok;

    int          check_errors;
    int          read_hits;
    int          read_misses;
    int          writes;
    logic [31:0] rng;

    tb_clock #(.PERIOD(100), .RESET_CYCLES(2)) u_clock (.clk(clk), .rst(rst));

    dcache_top #(
        .INDEX_WIDTH   (INDEX_WIDTH),
        .OFFSET_WIDTH  (2),
        .MEM_LATENCY   (MEM_LATENCY),
        .MEM_WORD_BITS (MEM_WORD_BITS)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok)
    );

    tb_checker #(
        .INDEX_WIDTH   (INDEX_WIDTH),
        .MEM_LATENCY   (MEM_LATENCY),
        .MEM_WORD_BITS (MEM_WORD_BITS)
    ) u_checker (
        .clk          (clk),
        .rst          (rst),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok),
        .errors       (check_errors),
        .read_hits    (read_hits),
        .read_misses  (read_misses),
        .writes       (writes)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // four tags over sixteen lines, all inside the 4 KiB memory
    function automatic addr_t pick_addr(input logic [1:0] tag_sel,
                                        input logic [INDEX_WIDTH-1:0] index,
                                        input logic [1:0] low, input size_t size);
        addr_t      tag_val;
        logic [1:0] off;
        case (tag_sel)
            2'd0:    tag_val = 32'h00;
            2'd1:    tag_val = 32'h13;
            2'd2:    tag_val = 32'h27;
            default: tag_val = 32'h3f;
        endcase
        case (size)
            SIZE_BYTE: off = low;
            SIZE_HALF: off = {low[1], 1'b0};
            default:   off = 2'b00;
        endcase
        return (tag_val << (INDEX_WIDTH + 2)) | (addr_t'(index) << 2) | addr_t'(off);
    endfunction

    // present one request and hold it until data_data_ok
    task automatic run_op(input logic wr, input size_t size, input addr_t addr,
                          input word_t wdata);
        data_req   = 1'b1;
        data_wr    = wr;
        data_size  = size;
        data_addr  = addr;
        data_wdata = wdata;
        @(negedge clk);
        while (data_data_ok !== 1'b1) begin
            @(negedge clk);
        end
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    initial begin : stimulus
        logic [31:0] r;
        logic        wr;
        size_t       size;
        addr_t       addr;
        word_t       wdata;
        logic        follow;
        addr_t       follow_addr;
        int          total_errors;
        data_req   = 1'b0;
        data_wr    = 1'b0;
        data_size  = SIZE_WORD;
        data_addr  = '0;
        data_wdata = '0;
        rng        = SEED;
        r          = '0;
        follow     = 1'b0;
        wait (rst === 1'b0);
        @(posedge clk);
        #DRIVE_DELAY;
        for (int n = 0; n < N_OPS; n++) begin
            if (follow) begin
                wr     = 1'b0;   // read back the whole word just written
                size   = SIZE_WORD;
                addr   = follow_addr;
                wdata  = '0;
                follow = 1'b0;
            end else begin
                rng         = xorshift32(rng);
                r           = rng;
                wr          = (r[2:0] < 3'd3);
                size        = (r[4:3] == 2'd3) ? SIZE_WORD : size_t'(r[4:3]);
                addr        = pick_addr(r[6:5], r[10:7], r[12:11], size);
                rng         = xorshift32(rng);
                wdata       = rng;
                follow      = wr && r[13];
                follow_addr = {addr[31:2], 2'b00};
            end
            run_op(wr, size, addr, wdata);
            if (r[16:14] == 3'd0) begin
                data_req = 1'b0;   // idle gap now and then
                @(posedge clk);
                #DRIVE_DELAY;
            end
        end
        data_req = 1'b0;
        repeat (4) @(posedge clk);
        total_errors = check_errors + UUT.u_cache.u_assertions.fail_count;
        $display("ops %0d, hits %0d, misses %0d, writes %0d, errors %0d, assert errors %0d",
                 N_OPS, read_hits, read_misses, writes, check_errors,
                 UUT.u_cache.u_assertions.fail_count);
        if (total_errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: dcache_top.f
dcache_pkg.sv
byte_merge.sv
dcache_write_through.sv
sram_like_mem.sv
dcache_top.sv
tb_clock.sv
dcache_assertions.sv
tb_checker.sv
tb_dcache_top.sv

// File: Bender.yml
package:
  name: dcache_top

sources:
  - dcache_pkg.sv
  - byte_merge.sv
  - dcache_write_through.sv
  - sram_like_mem.sv
  - dcache_top.sv
  - target: test
    files:
      - tb_clock.sv
      - dcache_assertions.sv
      - tb_checker.sv
      - tb_dcache_top.sv
